//--- files.f
+incdir+hdl
hdl/membus_pkg.sv
hdl/dram_queue.sv
hdl/dram_line_store.sv
hdl/dram_bus_port.sv
hdl/dram_subsys_top.sv
dv/dram_subsys_sva.sv
dv/dram_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the DRAM subsystem testbench with Verilator.
# Run from the project root.

TOP=dram_subsys_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f files.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- dv/dram_subsys_tb.sv
`timescale 1ns/100ps
`include "membus_cfg.svh"

module dram_subsys_tb;
  import membus_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int RAM_BASE     = `MB_RAM_BASE_LINE;
  localparam int RAM_LINES    = `MB_RAM_LINES;
  localparam int NACK_LIMIT   = `MB_REQ_DEPTH + `MB_RESP_DEPTH + `MB_DRAM_LATENCY + 2;
  localparam int RAND_SLOTS   = 200;
  localparam int DRAIN_MAX    = 40;   // idle slots allowed for the fills to come out
  localparam int MIN_IDLE     = 4;    // long enough for any stray fill to show
  localparam int TOTAL_SLOTS  = 50 + RAND_SLOTS + 7 * DRAIN_MAX;
  localparam int WATCHDOG_NS  = (TOTAL_SLOTS * `MB_SLOT_CYCLES + RESET_CYCLES) * CLK_PERIOD
                                + 2000;

  logic       clk;
  logic       rst;
  logic       bus_valid;
  logic       bus_nack;
  logic       bus_hit;
  bus_cmd_e   bus_cmd;
  bus_tag_t   bus_tag;
  line_addr_t bus_addr;
  beat_t      bus_data;
  logic       bus_dramctl_grant;
  logic       dramctl_bus_req;
  logic       dramctl_bus_nack;
  logic       dramctl_bus_fill_valid;
  bus_cmd_e   dramctl_bus_cmd;
  bus_tag_t   dramctl_bus_tag;
  line_addr_t dramctl_bus_addr;
  beat_t      dramctl_bus_data;

  slot_cyc_t  tb_cyc;
  int         seed = 32'h3d9be358;
  int         errors = 0;
  int         checks = 0;
  int         reads_accepted = 0;
  int         fills_seen = 0;
  logic       nack_allowed = 1'b0;
  string      test_name = "reset";
  bus_tag_t   next_tag = '0;
  line_data_t model_mem [line_addr_t];
  dram_resp_t exp_fills [$];

  dram_subsys_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst || tb_cyc == slot_cyc_t'(`MB_SLOT_CYCLES - 1)) tb_cyc <= '0;
    else tb_cyc <= tb_cyc + 3'd1;
  end

  // ----------------------------------------------------------
  // reference model and checks

  task automatic check_value(input string name, input logic [511:0] expected,
                             input logic [511:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  function automatic logic counts_for_dram(input logic nack, input logic hit,
                                           input bus_cmd_e cmd, input line_addr_t addr);
    logic is_read;
    logic in_ram;
    is_read = (cmd == cmd_busrd) || (cmd == cmd_busrdx);
    in_ram  = (int'(addr) >= RAM_BASE) && (int'(addr) < RAM_BASE + RAM_LINES);
    return !nack && in_ram && ((is_read && !hit) || cmd == cmd_flush);
  endfunction

  function automatic dram_resp_t expected_fill(input bus_tag_t tag, input line_addr_t addr);
    dram_resp_t r;
    r.tag  = tag;
    r.addr = addr;
    r.data = model_mem.exists(addr) ? model_mem[addr] : '0;
    return r;
  endfunction

  function automatic line_data_t random_line();
    line_data_t l;
    for (int i = 0; i < 16; i++) l[i*32 +: 32] = $random(seed);
    return l;
  endfunction

  initial begin : fill_compare
    line_data_t got;
    dram_resp_t want;
    forever begin
      @(negedge clk);
      if (!rst && dramctl_bus_fill_valid) begin
        got[int'(tb_cyc)*64 +: 64] = dramctl_bus_data;  // beat k shows in slot cycle k
        if (tb_cyc == slot_cyc_t'(`MB_SLOT_CYCLES - 1)) begin
          fills_seen++;
          if (exp_fills.size() == 0) begin
            errors++;
            $display("%s: fill with tag %0d arrived but none was expected",
                     test_name, dramctl_bus_tag);
          end else begin
            want = exp_fills.pop_front();
            check_value({test_name, " fill cmd"}, cmd_fill, dramctl_bus_cmd);
            check_value({test_name, " fill tag"}, want.tag, dramctl_bus_tag);
            check_value({test_name, " fill addr"}, want.addr, dramctl_bus_addr);
            check_value({test_name, " fill data"}, want.data, got);
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns while %s was running", WATCHDOG_NS, test_name);
    $display("Some tests failed");
    $finish;
  end

  // ----------------------------------------------------------
  // bus master

  task automatic run_slot(input logic valid, input logic nack, input logic hit,
                          input bus_cmd_e cmd, input bus_tag_t tag, input line_addr_t addr,
                          input line_data_t data, input logic grant, output logic nacked);
    do @(negedge clk); while (tb_cyc != 3'd0);
    for (int k = 0; k < `MB_SLOT_CYCLES; k++) begin
      if (k > 0) @(negedge clk);
      bus_data = data[k*64 +: 64];
      if (k == 3) begin
        bus_valid = valid;
        bus_nack  = nack;
        bus_hit   = hit;
        bus_cmd   = cmd;
        bus_tag   = tag;
        bus_addr  = addr;
      end
      if (k == 4) begin
        bus_valid = 1'b0;
        bus_nack  = 1'b0;
        bus_hit   = 1'b0;
        nacked    = dramctl_bus_nack;  // decided at the cycle 3 edge
      end
      if (k == 7) bus_dramctl_grant = grant;
    end
  endtask

  task automatic issue_cmd(input logic nack, input logic hit, input bus_cmd_e cmd,
                           input line_addr_t addr, input logic grant, output logic nacked);
    bus_tag_t   tag;
    line_data_t data;
    logic       relevant;
    tag      = next_tag;
    next_tag = next_tag + 5'd1;
    data     = random_line();
    run_slot(1'b1, nack, hit, cmd, tag, addr, data, grant, nacked);
    relevant = counts_for_dram(nack, hit, cmd, addr);
    if (!relevant) check_value({test_name, " nack on foreign command"}, 0, nacked);
    if (relevant && !nack_allowed) begin
      check_value({test_name, " nack with room in the queue"}, 0, nacked);
    end
    if (relevant && !nacked) begin
      if (cmd == cmd_flush) model_mem[addr] = data;
      else begin
        exp_fills.push_back(expected_fill(tag, addr));
        reads_accepted++;
      end
    end
  endtask

  task automatic drain_fills();
    logic nk;
    int   n;
    n = 0;
    while ((exp_fills.size() != 0 || n < MIN_IDLE) && n < DRAIN_MAX) begin
      run_slot(1'b0, 1'b0, 1'b0, cmd_busrd, '0, '0, '0, 1'b1, nk);
      n++;
    end
    if (exp_fills.size() != 0) begin
      errors++;
      $display("%s: %0d expected fills never arrived", test_name, exp_fills.size());
      exp_fills.delete();
    end
    check_value({test_name, " req with no line queued"}, 0, dramctl_bus_req);
  endtask

  // ----------------------------------------------------------
  // tests

  initial begin : main
    logic       nk;
    int         n;
    int         pick;
    logic       gr;
    bus_cmd_e   cmd;
    line_addr_t a;
    line_addr_t base;
    bus_valid = 1'b0;
    bus_nack  = 1'b0;
    bus_hit   = 1'b0;
    bus_cmd   = cmd_busrd;
    bus_tag   = '0;
    bus_addr  = '0;
    bus_data  = '0;
    bus_dramctl_grant = 1'b0;
    rst = 1'b1;
    base = line_addr_t'(RAM_BASE);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_name = "flush_then_read";
    issue_cmd(1'b0, 1'b0, cmd_flush, base + 26'd3, 1'b1, nk);
    issue_cmd(1'b0, 1'b0, cmd_busrd, base + 26'd3, 1'b1, nk);
    drain_fills();

    test_name = "foreign_commands";
    issue_cmd(1'b0, 1'b0, cmd_flush, base + 26'd5, 1'b1, nk);
    issue_cmd(1'b0, 1'b0, cmd_busrd, base - 26'd1, 1'b1, nk);
    issue_cmd(1'b0, 1'b0, cmd_flush, base + 26'd69, 1'b1, nk);  // aliases line 5 in the store
    issue_cmd(1'b0, 1'b0, cmd_busrdx, 26'd7, 1'b1, nk);
    issue_cmd(1'b1, 1'b0, cmd_busrd, base + 26'd5, 1'b1, nk);
    issue_cmd(1'b1, 1'b0, cmd_flush, base + 26'd5, 1'b1, nk);
    drain_fills();
    issue_cmd(1'b0, 1'b0, cmd_busrd, base + 26'd5, 1'b1, nk);
    drain_fills();

    test_name = "cache_hit";
    issue_cmd(1'b0, 1'b1, cmd_busrd, base + 26'd5, 1'b1, nk);
    issue_cmd(1'b0, 1'b1, cmd_flush, base + 26'd5, 1'b1, nk);
    issue_cmd(1'b0, 1'b0, cmd_busrdx, base + 26'd5, 1'b1, nk);
    drain_fills();

    test_name = "back_pressure";
    for (n = 0; n < 8; n++) issue_cmd(1'b0, 1'b0, cmd_flush, base + 26'(n), 1'b1, nk);
    drain_fills();
    nack_allowed = 1'b1;
    nk = 1'b0;
    for (n = 0; n < NACK_LIMIT && !nk; n++) begin
      issue_cmd(1'b0, 1'b0, cmd_busrd, base + 26'(n % 8), 1'b0, nk);
    end
    if (!nk) begin
      errors++;
      $display("back_pressure: no nack within %0d reads with grant held low", NACK_LIMIT);
    end
    issue_cmd(1'b0, 1'b0, cmd_busrd, base + 26'd1, 1'b0, nk);
    issue_cmd(1'b0, 1'b0, cmd_busrd, base + 26'd2, 1'b0, nk);
    check_value({test_name, " req with lines queued"}, 1, dramctl_bus_req);
    drain_fills();

    test_name = "random_mix";
    for (n = 0; n < RAND_SLOTS; n++) begin
      a    = base + 26'($unsigned($random(seed)) % RAM_LINES);
      pick = $unsigned($random(seed)) % 4;
      gr   = ($unsigned($random(seed)) % 2) == 1;
      cmd  = (pick < 2) ? cmd_flush : ((pick == 2) ? cmd_busrd : cmd_busrdx);
      if (cmd != cmd_flush && !model_mem.exists(a)) cmd = cmd_flush;  // read only known lines
      issue_cmd(1'b0, 1'b0, cmd, a, gr, nk);
    end
    drain_fills();

    test_name = "summary";
    check_value("fill count", reads_accepted, fills_seen);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- dv/dram_subsys_sva.sv
`timescale 1ns/100ps
`include "membus_cfg.svh"

module dram_subsys_sva (
  input logic                  clk,
  input logic                  rst,
  input membus_pkg::slot_cyc_t slot_cyc,
  input logic                  req_push,
  input logic [2:0]            req_free,
  input logic                  resp_pop,
  input logic                  resp_empty,
  input logic                  bus_dramctl_grant,
  input logic                  dramctl_bus_req,
  input logic                  dramctl_bus_nack,
  input logic                  dramctl_bus_fill_valid
);
  import membus_pkg::*;

  localparam slot_cyc_t CYC_LAST = slot_cyc_t'(`MB_SLOT_CYCLES - 1);

  // an accepted command and a nack cannot share a slot, and the push always finds room
  a_no_nack_on_push : assert property (@(posedge clk) disable iff (rst)
    req_push |-> !dramctl_bus_nack && (req_free != 3'd0))
    else $error("nack high or request queue full at a request push");

  a_pop_on_grant : assert property (@(posedge clk) disable iff (rst)
    resp_pop |-> (slot_cyc == CYC_LAST) && bus_dramctl_grant && !resp_empty)
    else $error("response popped outside slot cycle 7, without grant or from an empty queue");

  a_fill_level : assert property (@(posedge clk) disable iff (rst)
    (slot_cyc != CYC_LAST) |=> $stable(dramctl_bus_fill_valid))
    else $error("fill valid changed inside a slot");

  a_reset_state : assert property (@(posedge clk)
    rst |=> !dramctl_bus_req && !dramctl_bus_nack && !dramctl_bus_fill_valid)
    else $error("req, nack or fill valid high right after reset");

endmodule

bind dram_bus_port dram_subsys_sva u_sva (
  .clk                    (clk),
  .rst                    (rst),
  .slot_cyc               (slot_cyc),
  .req_push               (req_push),
  .req_free               (req_free),
  .resp_pop               (resp_pop),
  .resp_empty             (resp_empty),
  .bus_dramctl_grant      (bus_dramctl_grant),
  .dramctl_bus_req        (dramctl_bus_req),
  .dramctl_bus_nack       (dramctl_bus_nack),
  .dramctl_bus_fill_valid (dramctl_bus_fill_valid)
);

//--- hdl/dram_subsys_top.sv
`timescale 1ns/100ps
`include "membus_cfg.svh"

module dram_subsys_top (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   bus_valid,
  input  logic                   bus_nack,
  input  logic                   bus_hit,
  input  membus_pkg::bus_cmd_e   bus_cmd,
  input  membus_pkg::bus_tag_t   bus_tag,
  input  membus_pkg::line_addr_t bus_addr,
  input  membus_pkg::beat_t      bus_data,
  input  logic                   bus_dramctl_grant,

  output logic                   dramctl_bus_req,
  output logic                   dramctl_bus_nack,
  output logic                   dramctl_bus_fill_valid,
  output membus_pkg::bus_cmd_e   dramctl_bus_cmd,
  output membus_pkg::bus_tag_t   dramctl_bus_tag,
  output membus_pkg::line_addr_t dramctl_bus_addr,
  output membus_pkg::beat_t      dramctl_bus_data
);
  import membus_pkg::*;

  dram_req_t  req_in;
  dram_req_t  req_out;
  dram_resp_t resp_in;
  dram_resp_t resp_out;
  logic       req_push;
  logic       req_pop;
  logic       req_empty;
  logic [2:0] req_free;
  logic       resp_push;
  logic       resp_pop;
  logic       resp_empty;
  logic [2:0] resp_free;

  dram_bus_port u_port (
    .clk                    (clk),
    .rst                    (rst),
    .bus_valid              (bus_valid),
    .bus_nack               (bus_nack),
    .bus_hit                (bus_hit),
    .bus_cmd                (bus_cmd),
    .bus_tag                (bus_tag),
    .bus_addr               (bus_addr),
    .bus_data               (bus_data),
    .bus_dramctl_grant      (bus_dramctl_grant),
    .dramctl_bus_req        (dramctl_bus_req),
    .dramctl_bus_nack       (dramctl_bus_nack),
    .dramctl_bus_fill_valid (dramctl_bus_fill_valid),
    .dramctl_bus_cmd        (dramctl_bus_cmd),
    .dramctl_bus_tag        (dramctl_bus_tag),
    .dramctl_bus_addr       (dramctl_bus_addr),
    .dramctl_bus_data       (dramctl_bus_data),
    .req_push               (req_push),
    .req_data               (req_in),
    .req_free               (req_free),
    .resp_pop               (resp_pop),
    .resp_data              (resp_out),
    .resp_empty             (resp_empty)
  );

  // ----------------------------------------------------------
  // command queue, bus side to store side

  dram_queue #(
    .WIDTH ($bits(dram_req_t)),
    .DEPTH (`MB_REQ_DEPTH)
  ) u_req_q (
    .clk       (clk),
    .rst       (rst),
    .push      (req_push),
    .push_data (req_in),
    .pop       (req_pop),
    .pop_data  (req_out),
    .empty     (req_empty),
    .full      (),
    .free      (req_free)
  );

  dram_line_store u_store (
    .clk       (clk),
    .rst       (rst),
    .req_pop   (req_pop),
    .req_data  (req_out),
    .req_empty (req_empty),
    .resp_push (resp_push),
    .resp_data (resp_in),
    .resp_free (resp_free)
  );

  // ----------------------------------------------------------
  // read line queue, store side to bus side

  dram_queue #(
    .WIDTH ($bits(dram_resp_t)),
    .DEPTH (`MB_RESP_DEPTH)
  ) u_resp_q (
    .clk       (clk),
    .rst       (rst),
    .push      (resp_push),
    .push_data (resp_in),
    .pop       (resp_pop),
    .pop_data  (resp_out),
    .empty     (resp_empty),
    .full      (),
    .free      (resp_free)
  );

endmodule

//--- hdl/dram_bus_port.sv
`timescale 1ns/100ps
`include "membus_cfg.svh"

module dram_bus_port (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   bus_valid,
  input  logic                   bus_nack,
  input  logic                   bus_hit,
  input  membus_pkg::bus_cmd_e   bus_cmd,
  input  membus_pkg::bus_tag_t   bus_tag,
  input  membus_pkg::line_addr_t bus_addr,
  input  membus_pkg::beat_t      bus_data,
  input  logic                   bus_dramctl_grant,

  output logic                   dramctl_bus_req,
  output logic                   dramctl_bus_nack,
  output logic                   dramctl_bus_fill_valid,
  output membus_pkg::bus_cmd_e   dramctl_bus_cmd,
  output membus_pkg::bus_tag_t   dramctl_bus_tag,
  output membus_pkg::line_addr_t dramctl_bus_addr,
  output membus_pkg::beat_t      dramctl_bus_data,

  output logic                   req_push,
  output membus_pkg::dram_req_t  req_data,
  input  logic [2:0]             req_free,

  output logic                   resp_pop,
  input  membus_pkg::dram_resp_t resp_data,
  input  logic                   resp_empty
);
  import membus_pkg::*;

  localparam line_addr_t RAM_BASE   = line_addr_t'(`MB_RAM_BASE_LINE);
  localparam line_addr_t RAM_END    = line_addr_t'(`MB_RAM_BASE_LINE + `MB_RAM_LINES);
  localparam slot_cyc_t  CYC_LAST   = slot_cyc_t'(`MB_SLOT_CYCLES - 1);
  localparam slot_cyc_t  CYC_PUSH   = slot_cyc_t'(0);
  localparam slot_cyc_t  CYC_DECODE = slot_cyc_t'(3);
  localparam slot_cyc_t  CYC_GRANT  = slot_cyc_t'(7);
  localparam int         BEAT_W     = $bits(beat_t);

  slot_cyc_t  slot_cyc;
  logic       cmd_is_read;
  logic       cmd_is_flush;
  logic       in_window;
  logic       cmd_relevant;
  logic       req_room;
  logic       cmd_valid_r;
  logic       cmd_write_r;
  bus_tag_t   cmd_tag_r;
  store_idx_t cmd_idx_r;
  line_data_t wdata_r;
  line_data_t fill_line_r;

  // ----------------------------------------------------------
  // slot counter and command decode

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_cyc <= '0;
    end else if (slot_cyc == CYC_LAST) begin
      slot_cyc <= '0;
    end else begin
      slot_cyc <= slot_cyc + 1'b1;
    end
  end

  always_comb begin
    cmd_is_read  = 1'b0;
    cmd_is_flush = 1'b0;
    case (bus_cmd)
      cmd_busrd, cmd_busrdx: cmd_is_read  = 1'b1;
      cmd_flush:             cmd_is_flush = 1'b1;
      default: ;                                  // fills and unknown codes are not ours
    endcase
  end

  assign in_window    = (bus_addr >= RAM_BASE) && (bus_addr < RAM_END);
  assign cmd_relevant = bus_valid & ~bus_nack & in_window &
                        ((cmd_is_read & ~bus_hit) | cmd_is_flush);  // a flush lands even on a hit

  // the previous command was pushed at cycle 0, so the free count is current here
  assign req_room = (req_free != 3'd0);

  // ----------------------------------------------------------
  // accept or nack, then hand over at the next slot boundary

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_valid_r      <= 1'b0;
      dramctl_bus_nack <= 1'b0;
    end else if (slot_cyc == CYC_DECODE) begin
      cmd_valid_r      <= cmd_relevant & req_room;
      dramctl_bus_nack <= cmd_relevant & ~req_room;  // held until the next decode cycle
    end
  end

  always_ff @(posedge clk) begin
    if (slot_cyc == CYC_DECODE) begin
      cmd_write_r <= cmd_is_flush;
      cmd_tag_r   <= bus_tag;
      cmd_idx_r   <= store_idx_t'(bus_addr - RAM_BASE);
    end
  end

  always_ff @(posedge clk) begin
    wdata_r[slot_cyc*BEAT_W +: BEAT_W] <= bus_data;  // beat number follows the slot cycle
  end

  assign req_push = cmd_valid_r & (slot_cyc == CYC_PUSH);

  always_comb begin
    req_data.wr   = cmd_write_r;
    req_data.tag  = cmd_tag_r;
    req_data.idx  = cmd_idx_r;
    req_data.data = wdata_r;
  end

  // ----------------------------------------------------------
  // bus request and fill slot

  assign resp_pop = (slot_cyc == CYC_GRANT) & dramctl_bus_req & bus_dramctl_grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      dramctl_bus_req        <= 1'b0;
      dramctl_bus_fill_valid <= 1'b0;
    end else if (slot_cyc == CYC_GRANT) begin
      // the line popped now may have been the last one, so skip a slot after a fill
      dramctl_bus_req        <= ~resp_empty & ~resp_pop;
      dramctl_bus_fill_valid <= resp_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_pop) begin
      dramctl_bus_tag  <= resp_data.tag;
      dramctl_bus_addr <= resp_data.addr;
      fill_line_r      <= resp_data.data;
    end
  end

  assign dramctl_bus_cmd  = cmd_fill;
  assign dramctl_bus_data = fill_line_r[slot_cyc*BEAT_W +: BEAT_W];

endmodule

//--- hdl/dram_line_store.sv
`timescale 1ns/100ps
`include "membus_cfg.svh"

module dram_line_store (
  input  logic                   clk,
  input  logic                   rst,

  output logic                   req_pop,
  input  membus_pkg::dram_req_t  req_data,
  input  logic                   req_empty,

  output logic                   resp_push,
  output membus_pkg::dram_resp_t resp_data,
  input  logic [2:0]             resp_free
);
  import membus_pkg::*;

  localparam int         LAT      = `MB_DRAM_LATENCY;
  localparam line_addr_t RAM_BASE = line_addr_t'(`MB_RAM_BASE_LINE);

  line_data_t mem [`MB_RAM_LINES];

  logic [LAT-1:0] pipe_vld;
  bus_tag_t       pipe_tag  [LAT];
  store_idx_t     pipe_idx  [LAT];
  line_data_t     pipe_data [LAT];
  logic [2:0]     inflight;
  logic           rd_ok;
  logic           rd_issue;

  // ----------------------------------------------------------
  // request side

  // every read in the pipe already owns one free response slot
  assign rd_ok    = (resp_free > inflight);
  assign req_pop  = ~req_empty & (req_data.wr | rd_ok);
  assign rd_issue = req_pop & ~req_data.wr;

  always_ff @(posedge clk) begin
    if (req_pop && req_data.wr) begin
      mem[req_data.idx] <= req_data.data;
    end
  end

  // ----------------------------------------------------------
  // read pipeline

  always_ff @(posedge clk) begin
    if (rst) begin
      pipe_vld <= '0;
    end else begin
      pipe_vld <= {pipe_vld[LAT-2:0], rd_issue};
    end
  end

  always_ff @(posedge clk) begin
    pipe_tag[0]  <= req_data.tag;
    pipe_idx[0]  <= req_data.idx;
    pipe_data[0] <= mem[req_data.idx];  // array is read at pop time
    for (int i = 1; i < LAT; i++) begin
      pipe_tag[i]  <= pipe_tag[i-1];
      pipe_idx[i]  <= pipe_idx[i-1];
      pipe_data[i] <= pipe_data[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      inflight <= '0;
    end else begin
      case ({rd_issue, resp_push})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------
  // response side

  assign resp_push = pipe_vld[LAT-1];

  always_comb begin
    resp_data.tag  = pipe_tag[LAT-1];
    resp_data.addr = RAM_BASE + line_addr_t'(pipe_idx[LAT-1]);  // back to a bus line address
    resp_data.data = pipe_data[LAT-1];
  end

endmodule

//--- hdl/dram_queue.sv
`timescale 1ns/100ps

module dram_queue #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             empty,
  output logic             full,
  output logic [2:0]       free
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PW-1:0]    wr_ptr;
  logic [PW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign full     = (count == CW'(DEPTH));
  assign free     = 3'(DEPTH - int'(count));
  assign do_pop   = pop & ~empty;
  assign do_push  = push & (~full | do_pop);  // a full queue takes a push alongside a pop
  assign pop_data = mem[rd_ptr];              // head is visible before the pop

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- hdl/membus_pkg.sv
package membus_pkg;

  // ----------------------------------------------------------
  // bus fields

  typedef logic [31:6]  line_addr_t;  // one cache line of byte address space
  typedef logic [4:0]   bus_tag_t;
  typedef logic [63:0]  beat_t;
  typedef logic [511:0] line_data_t;  // beat 0 sits in the low bits

  typedef logic [5:0]   store_idx_t;  // line index inside the RAM window
  typedef logic [2:0]   slot_cyc_t;   // position within a bus slot

  typedef enum logic [2:0] {
    cmd_busrd  = 3'd0,
    cmd_busrdx = 3'd1,
    cmd_flush  = 3'd2,
    cmd_fill   = 3'd3
  } bus_cmd_e;

  // ----------------------------------------------------------
  // controller internal transfers

  // one accepted bus command on its way to the line store
  typedef struct packed {
    logic       wr;    // flush carries a line to write
    bus_tag_t   tag;
    store_idx_t idx;
    line_data_t data;
  } dram_req_t;

  // one read line on its way back to the bus
  typedef struct packed {
    bus_tag_t   tag;
    line_addr_t addr;
    line_data_t data;
  } dram_resp_t;

endpackage

//--- hdl/membus_cfg.svh
`ifndef MEMBUS_CFG_SVH
`define MEMBUS_CFG_SVH

// ----------------------------------------------------------
// bus timing

`define MB_SLOT_CYCLES    8        // clock cycles in one bus slot

// ----------------------------------------------------------
// memory map, in 64-byte lines

`define MB_RAM_BASE_LINE  8388608  // 0x20000000 / 64
`define MB_RAM_LINES      64       // size of the line store

// ----------------------------------------------------------
// controller buffering

`define MB_REQ_DEPTH      4        // commands waiting for the line store
`define MB_RESP_DEPTH     4        // read lines waiting for a fill slot
`define MB_DRAM_LATENCY   6        // read pipeline stages in the store

`endif
